//--- compile.f
+incdir+include
src/pitch_game_pkg.sv
src/period_meter.sv
src/note_classifier.sv
src/note_filter.sv
src/melody_game.sv
src/pitch_game_top.sv
tb/tb_pitch_game.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pitch_game \
    -f compile.f

./obj_dir/Vtb_pitch_game

//--- tb/tb_pitch_game.sv
`timescale 1ns/1ps

module tb_pitch_game;
    import pitch_game_pkg::*;

    localparam int clk_mhz      = 1;
    localparam int stable_log2  = 4;
    localparam int rest_period  = 100;
    // Tones sung over the whole run, with a margin for the random counts
    localparam longint tone_count  = 12 + melody_len + 10 + 4;
    localparam longint watchdog_ns = tone_count * 4 * 2000 * 4 * 3 / 2;

    logic          clk;
    logic          rst;
    logic          key;
    mic_sample_t   mic;
    note_t         note;
    game_state_t   game_state;
    melody_index_t melody_index;
    logic          success;
    logic          failure;

    logic [31:0]   lcg_state = 32'hf84789e1;
    game_state_t   exp_state;
    int            exp_index;
    logic          exp_success;
    logic          exp_failure;

    pitch_game_top #(
        .clk_mhz     (clk_mhz),
        .stable_log2 (stable_log2)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .mic          (mic),
        .note         (note),
        .game_state   (game_state),
        .melody_index (melody_index),
        .success      (success),
        .failure      (failure)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic end_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        assert (actual == expected) else begin
            $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_game();
        check_value("game_state", longint'(exp_state), longint'(game_state));
        check_value("melody_index", exp_index, melody_index);
        check_value("success", exp_success, success);
        check_value("failure", exp_failure, failure);
    endtask

    // Window center for semitone s at octave multiplier k
    function automatic int tone_period(input int s, input int k);
        return int'((longint'(clk_mhz) * 100_000_000) / (longint'(note_freq_100[s]) * k));
    endfunction

    function automatic int note_bit(input note_t n);
        int pos;
        pos = 0;
        for (int i = 0; i < num_notes; i++)
            if (n[i])
                pos = i;
        return pos;
    endfunction

    // Game rules applied to one expected strobe
    function automatic void apply_strobe(input note_t n);
        if (exp_state == game_playing) begin
            if (n == melody[exp_index]) begin
                exp_success = 1'b1;
                exp_failure = 1'b0;
                if (exp_index == melody_len - 1)
                    exp_state = game_win;
                else
                    exp_index++;
            end else begin
                exp_success = 1'b0;
                exp_failure = 1'b1;
                exp_index   = 0;
                exp_state   = game_fail;
            end
        end
    endfunction

    task automatic drive_half(input int cycles, input bit negative);
        logic [31:0] r;
        mic_sample_t mag;
        for (int i = 0; i < cycles; i++) begin
            r   = next_random();
            mag = mic_sample_t'({1'b0, r[22:0]});
            @(posedge clk);
            mic <= negative ? ~mag : mag;
        end
    endtask

    // Positive half first, so every crossing spans one full period
    task automatic play_wave(input int period, input int periods);
        repeat (periods) begin
            drive_half(period - period / 2, 1'b0);
            drive_half(period / 2, 1'b1);
        end
    endtask

    task automatic rest();
        play_wave(rest_period, 4);
        @(negedge clk);
        check_value("note", note_none, note);
        check_game();
    endtask

    task automatic sing(input int s);
        int k;
        k = 1 << (next_random() % 3);
        play_wave(tone_period(s, k), 4);
        @(negedge clk);
        check_value("note", note_t'(1) << s, note);
        apply_strobe(note_t'(1) << s);
        check_game();
        rest();
    endtask

    task automatic press_key(input int hold_cycles);
        game_state_t next_state;
        next_state = (exp_state == game_idle) ? game_playing : game_idle;
        @(posedge clk);
        key <= 1'b1;
        // Edge register, then state register
        repeat (2) begin
            @(negedge clk);
            check_game();
        end
        @(negedge clk);
        exp_state = next_state;
        if (next_state == game_playing)
            exp_index = 0;
        check_game();
        // Flags hold on the transition and clear one cycle later in idle
        if (next_state == game_idle) begin
            exp_success = 1'b0;
            exp_failure = 1'b0;
        end
        repeat (hold_cycles) begin
            @(negedge clk);
            check_game();
        end
        @(posedge clk);
        key <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Checks over the whole run
    // ------------------------------------------------------------

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(success && failure))
        else begin
            $display("Error: success and failure are high together at %0t", $time);
            end_with_failure();
        end

    a_index_step: assert property (@(posedge clk) disable iff (rst)
        (melody_index != $past(melody_index)) |->
            (melody_index == $past(melody_index) + 1'b1 || melody_index == '0))
        else begin
            $display("Error: melody_index moved by more than one step at %0t", $time);
            end_with_failure();
        end

    initial begin
        #(watchdog_ns);
        $display("Error: the run did not finish within %0d ns", watchdog_ns);
        end_with_failure();
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        int n_good;
        int s;
        rst         = 1'b1;
        key         = 1'b0;
        mic         = '0;
        exp_state   = game_idle;
        exp_index   = 0;
        exp_success = 1'b0;
        exp_failure = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("note", note_none, note);
        check_game();
        rest();

        // Every semitone at a random octave, game stays idle
        for (int i = num_notes - 1; i >= 0; i--)
            sing(i);

        // Start, holding the key down
        press_key(8);

        // Full melody
        for (int i = 0; i < melody_len; i++)
            sing(note_bit(melody[i]));
        press_key(2);

        // Some correct notes, then a wrong one
        press_key(2);
        n_good = 1 + int'(next_random() % 8);
        repeat (n_good)
            sing(note_bit(melody[exp_index]));
        do begin
            s = int'(next_random() % num_notes);
        end while ((note_t'(1) << s) == melody[exp_index]);
        sing(s);
        press_key(2);

        // Abort in the middle of the melody
        press_key(2);
        repeat (2)
            sing(note_bit(melody[exp_index]));
        press_key(2);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- src/pitch_game_top.sv
`timescale 1ns/1ps

module pitch_game_top #(
    parameter int clk_mhz     = 50,
    parameter int stable_log2 = 20
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          key,
    input  pitch_game_pkg::mic_sample_t   mic,
    output pitch_game_pkg::note_t         note,
    output pitch_game_pkg::game_state_t   game_state,
    output pitch_game_pkg::melody_index_t melody_index,
    output logic                          success,
    output logic                          failure
);
    import pitch_game_pkg::*;

    period_t period;
    note_t   raw_note;
    logic    note_strobe;

    // Microphone to period, period to semitone
    period_meter u_period_meter (
        .clk    (clk),
        .rst    (rst),
        .mic    (mic),
        .period (period)
    );

    note_classifier #(
        .clk_mhz (clk_mhz)
    ) u_note_classifier (
        .clk      (clk),
        .rst      (rst),
        .period   (period),
        .raw_note (raw_note)
    );

    note_filter #(
        .stable_log2 (stable_log2)
    ) u_note_filter (
        .clk         (clk),
        .rst         (rst),
        .raw_note    (raw_note),
        .note        (note),
        .note_strobe (note_strobe)
    );

    melody_game u_melody_game (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .note         (note),
        .note_strobe  (note_strobe),
        .game_state   (game_state),
        .melody_index (melody_index),
        .success      (success),
        .failure      (failure)
    );

endmodule

//--- src/melody_game.sv
`timescale 1ns/1ps

module melody_game (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          key,
    input  pitch_game_pkg::note_t         note,
    input  logic                          note_strobe,
    output pitch_game_pkg::game_state_t   game_state,
    output pitch_game_pkg::melody_index_t melody_index,
    output logic                          success,
    output logic                          failure
);
    import pitch_game_pkg::*;

    logic key_d;
    logic key_edge;

    // ----------------------------------------------------------
    // Key rising edge, registered
    // ----------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_d    <= 1'b0;
            key_edge <= 1'b0;
        end else begin
            key_d    <= key;
            key_edge <= key && !key_d;
        end
    end

    // ----------------------------------------------------------
    // Game FSM
    // ----------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state   <= game_idle;
            melody_index <= '0;
            success      <= 1'b0;
            failure      <= 1'b0;
        end else begin
            unique case (game_state)
                game_idle: begin
                    success <= 1'b0;
                    failure <= 1'b0;
                    if (key_edge) begin
                        game_state   <= game_playing;
                        melody_index <= '0;
                    end
                end

                game_playing: begin
                    if (key_edge) begin
                        game_state <= game_idle;
                    end else if (note_strobe) begin
                        if (note == melody[melody_index]) begin
                            success <= 1'b1;
                            failure <= 1'b0;
                            // Last entry sung means the whole melody is done
                            if (melody_index == melody_index_t'(melody_len - 1))
                                game_state <= game_win;
                            else
                                melody_index <= melody_index + 1'b1;
                        end else begin
                            success      <= 1'b0;
                            failure      <= 1'b1;
                            melody_index <= '0;
                            game_state   <= game_fail;
                        end
                    end
                end

                game_win,
                game_fail: begin
                    if (key_edge)
                        game_state <= game_idle;
                end

                default: game_state <= game_idle;
            endcase
        end
    end

    a_index_range: assert property (
        @(posedge clk) disable iff (rst)
        melody_index < melody_len
    );

endmodule

//--- src/note_filter.sv
`timescale 1ns/1ps

module note_filter #(
    parameter int stable_log2 = 20
) (
    input  logic                  clk,
    input  logic                  rst,
    input  pitch_game_pkg::note_t raw_note,
    output pitch_game_pkg::note_t note,
    output logic                  note_strobe
);
    import pitch_game_pkg::*;

    note_t                    d_note;
    logic [stable_log2 - 1:0] stable_cnt;
    logic                     stable;

    assign stable = &stable_cnt;

    // Delayed copy and stability count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_note     <= note_none;
            stable_cnt <= '0;
        end else begin
            d_note <= raw_note;
            if (raw_note != d_note)
                stable_cnt <= '0;
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Accepted note, strobe only on a change to a real note
    // ----------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            note        <= note_none;
            note_strobe <= 1'b0;
        end else begin
            note_strobe <= stable && (d_note != note) && (d_note != note_none);
            if (stable)
                note <= d_note;
        end
    end

    a_strobe_single: assert property (
        @(posedge clk) disable iff (rst)
        note_strobe |=> !note_strobe
    );

endmodule

//--- src/note_classifier.sv
`timescale 1ns/1ps

module note_classifier #(
    parameter int clk_mhz = 50
) (
    input  logic                    clk,
    input  logic                    rst,
    input  pitch_game_pkg::period_t period,
    output pitch_game_pkg::note_t   raw_note
);
    import pitch_game_pkg::*;

    logic [num_notes - 1:0] hit;
    note_t                  picked;

    // ----------------------------------------------------------
    // Window match per semitone, three octaves each
    // ----------------------------------------------------------

    for (genvar s = 0; s < num_notes; s++) begin : g_note
        logic [2:0] in_win;

        for (genvar o = 0; o < 3; o++) begin : g_oct
            // Multiply before dividing to keep precision at slow clocks
            localparam longint unsigned freq_k = longint'(note_freq_100[s]) << o;
            localparam longint unsigned lo     = longint'(clk_mhz) * 64'd97_000_000 / freq_k;
            localparam longint unsigned hi     = longint'(clk_mhz) * 64'd103_000_000 / freq_k;

            assign in_win[o] = (64'(period) > lo) && (64'(period) < hi);
        end

        assign hit[s] = |in_win;
    end

    // Overlapping windows, highest bit (toward C) wins
    always_comb begin
        picked = note_none;
        for (int i = 0; i < num_notes; i++) begin
            if (hit[i])
                picked = note_t'(1) << i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            raw_note <= note_none;
        else
            raw_note <= picked;
    end

    a_raw_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(raw_note));

endmodule

//--- src/period_meter.sv
`timescale 1ns/1ps

module period_meter (
    input  logic                        clk,
    input  logic                        rst,
    input  pitch_game_pkg::mic_sample_t mic,
    output pitch_game_pkg::period_t     period
);
    import pitch_game_pkg::*;

    logic    prev_neg;
    logic    crossing;
    period_t count;

    // Negative to non-negative transition of the sample
    assign crossing = prev_neg && !mic[$left(mic)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_neg <= 1'b0;
            count    <= '0;
            period   <= '0;
        end else begin
            prev_neg <= mic[$left(mic)];

            if (crossing) begin
                period <= count;
                count  <= '0;
            end else if (count != '1) begin
                // Stick at all ones when no tone is present
                count <= count + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    a_count_saturates: assert property (
        @(posedge clk) disable iff (rst)
        (count == '1 && !crossing) |=> (count == '1)
    );

endmodule

//--- src/pitch_game_pkg.sv
package pitch_game_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------

    typedef logic signed [23:0] mic_sample_t;

    // All ones marks "no crossing seen yet"
    typedef logic [19:0] period_t;

    // One-hot semitone, bit 11 is C down to bit 0 is B
    typedef logic [11:0] note_t;

    localparam int    num_notes = 12;
    localparam note_t note_none = '0;

    // Names used by the melody table
    localparam note_t note_c = note_t'(1) << 11;
    localparam note_t note_d = note_t'(1) << 9;
    localparam note_t note_e = note_t'(1) << 7;
    localparam note_t note_f = note_t'(1) << 6;
    localparam note_t note_g = note_t'(1) << 4;
    localparam note_t note_a = note_t'(1) << 2;

    // Frequency x 100, indexed by note bit position (11 = C, 0 = B)
    localparam int unsigned note_freq_100 [num_notes - 1:0] = '{
        52325, 55437, 58733, 62225, 65926, 69846,
        73999, 78399, 83061, 88000, 93233, 98777
    };

    // ----------------------------------------------------------
    // Game
    // ----------------------------------------------------------

    localparam int melody_len = 62;

    typedef logic [5:0] melody_index_t;

    typedef enum logic [1:0] {
        game_idle,
        game_playing,
        game_win,
        game_fail
    } game_state_t;

`include "melody_table.svh"

endpackage

//--- include/melody_table.svh
`ifndef MELODY_TABLE_SVH
`define MELODY_TABLE_SVH

// Melody to be sung, one note code per entry
localparam note_t melody [melody_len] = '{
    // Phrase 1
    note_e,
    note_g,
    note_d,
    note_c,
    note_d,
    note_e,
    note_g,
    note_d,
    // Phrase 2
    note_e,
    note_g,
    note_d,
    note_c,
    note_g,
    note_f,
    note_e,
    note_d,
    // Phrase 1 again
    note_e,
    note_g,
    note_d,
    note_c,
    note_d,
    note_e,
    note_g,
    note_d,
    // Short ending
    note_e,
    note_g,
    note_d,
    note_c,
    note_g,
    // Bridge
    note_g,
    note_f,
    note_e,
    note_f,
    note_e,
    note_c,
    note_f,
    note_e,
    note_d,
    note_e,
    note_d,
    note_a,
    note_g,
    note_f,
    note_e,
    note_f,
    note_e,
    note_c,
    note_f,
    note_c,
    // Reprise
    note_e,
    note_g,
    note_d,
    note_c,
    note_d,
    note_e,
    note_g,
    note_d,
    note_e,
    note_g,
    note_d,
    note_c,
    note_g
};

`endif
